/* uart_dbg_defs.svh */
/*
  Constants shared by the UART debug server.
  Holds the baud divider, protocol byte values, field lengths and RAM size.
  Include it in any file that uses one of these values.
*/
`ifndef UART_DBG_DEFS_SVH
`define UART_DBG_DEFS_SVH

// Clock cycles per serial bit
`define UART_DBG_CLKS_PER_BIT 16

// Command bytes sent by the host
`define UART_DBG_CMD_READ  8'h11
`define UART_DBG_CMD_WRITE 8'h12
`define UART_DBG_CMD_EXEC  8'h13

// Reply bytes
`define UART_DBG_ACK 8'h06
`define UART_DBG_EOT 8'h04

// Field lengths in bytes, sent LSB first
`define UART_DBG_ADDR_BYTES 4
`define UART_DBG_LEN_BYTES  2

// On-chip RAM size in bytes; higher addresses wrap around
`define UART_DBG_RAM_BYTES 1024

`endif

/* uart_dbg_pkg.sv */
/*
  Types of the UART debug server.
  Holds the command and controller state enums and the structs for the
  received byte stream and the byte-wide Wishbone bus.
*/
`include "uart_dbg_defs.svh"

package uart_dbg_pkg;

  // Command bytes the controller acts on
  typedef enum logic [7:0] {
    CMD_ACK   = `UART_DBG_ACK,
    CMD_READ  = `UART_DBG_CMD_READ,
    CMD_WRITE = `UART_DBG_CMD_WRITE,
    CMD_EXEC  = `UART_DBG_CMD_EXEC
  } dbg_cmd_e;

  // Controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_ACK,
    ST_RD_DATA,
    ST_WR_DATA,
    ST_EOT,
    ST_EXEC
  } dbg_state_e;

  // One received byte, valid for a single cycle
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strm_t;

  // Wishbone classic, byte wide, master side
  typedef struct packed {
    logic                              cyc;
    logic                              stb;
    logic                              we;
    logic [`UART_DBG_ADDR_BYTES*8-1:0] adr;
    logic [7:0]                        dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

endpackage

/* uart_rx.sv */
/*
  8N1 serial receiver.
  Synchronizes the line, finds the start bit and samples each bit at its
  middle. Emits one single-cycle valid byte per good frame and drops frames
  whose stop bit is missing.
*/
`timescale 1ns/1ps
`include "uart_dbg_defs.svh"

module uart_rx (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    rx_i,
  output uart_dbg_pkg::byte_strm_t byte_o
);

  localparam int unsigned CLKS  = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned HALF  = CLKS / 2;
  localparam int unsigned CNT_W = $clog2(CLKS);

  logic [1:0]       sync_q;
  logic             rx_prev_q;
  logic             busy_q;
  logic [CNT_W-1:0] baud_q;
  logic [3:0]       bit_q;
  logic [7:0]       shift_q;
  logic             valid_q;
  logic             rx_s;
  logic             sample;

  // Synchronized line level
  assign rx_s   = sync_q[1];
  assign sample = busy_q && (baud_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
      busy_q    <= 1'b0;
      baud_q    <= '0;
      bit_q     <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;
      valid_q   <= 1'b0;
      if (!busy_q) begin
        // Falling edge starts a frame, first sample half a bit later
        if (rx_prev_q && !rx_s) begin
          busy_q <= 1'b1;
          baud_q <= CNT_W'(HALF - 1);
          bit_q  <= '0;
        end
      end else if (sample) begin
        baud_q <= CNT_W'(CLKS - 1);
        bit_q  <= bit_q + 4'd1;
        if (bit_q == 4'd0 && rx_s) begin
          // Glitch, not a real start bit
          busy_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= rx_s;
        end
      end else begin
        baud_q <= baud_q - 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign byte_o = '{valid: valid_q, data: shift_q};

endmodule

/* uart_tx.sv */
/*
  8N1 serial transmitter.
  Takes one byte on a valid/ready handshake and sends start bit, eight
  data bits LSB first and stop bit. Ready stays low for the whole frame.
*/
`timescale 1ns/1ps
`include "uart_dbg_defs.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  output logic       tx_o
);

  localparam int unsigned CLKS  = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned CNT_W = $clog2(CLKS);

  logic             busy_q;
  logic             tx_q;
  logic [CNT_W-1:0] baud_q;
  logic [3:0]       bit_q;
  // Stop bit above the data bits
  logic [8:0]       shift_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      tx_q   <= 1'b1;
      baud_q <= '0;
      bit_q  <= '0;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        // Start bit goes out right away
        busy_q  <= 1'b1;
        tx_q    <= 1'b0;
        shift_q <= {1'b1, tx_data_i};
        baud_q  <= CNT_W'(CLKS - 1);
        bit_q   <= '0;
      end
    end else if (baud_q == '0) begin
      if (bit_q == 4'd9) begin
        // Stop bit done
        busy_q <= 1'b0;
      end else begin
        tx_q    <= shift_q[0];
        shift_q <= {1'b1, shift_q[8:1]};
        bit_q   <= bit_q + 4'd1;
        baud_q  <= CNT_W'(CLKS - 1);
      end
    end else begin
      baud_q <= baud_q - 1'b1;
    end
  end

  assign tx_ready_o = !busy_q;
  assign tx_o       = tx_q;

  // A waiting byte must not move until the frame starts
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (tx_valid_i && !tx_ready_o) |=> (tx_valid_i && $stable(tx_data_i)))
    else $error("uart_tx: byte withdrawn or changed before acceptance");

endmodule

/* uart_dbg_ctrl.sv */
/*
  Debug protocol controller.
  Parses read, write, exec and ACK challenge commands from the receiver,
  runs single-beat Wishbone accesses for the data bytes and answers the
  host through the transmitter.
*/
`timescale 1ns/1ps
`include "uart_dbg_defs.svh"

module uart_dbg_ctrl (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  uart_dbg_pkg::byte_strm_t            rx_byte_i,
  output logic [7:0]                          tx_data_o,
  output logic                                tx_valid_o,
  input  logic                                tx_ready_i,
  output uart_dbg_pkg::wb_req_t               wb_req_o,
  input  uart_dbg_pkg::wb_rsp_t               wb_rsp_i,
  output logic [`UART_DBG_ADDR_BYTES*8-1:0]   exec_addr_o,
  output logic                                exec_valid_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned ADDR_W = `UART_DBG_ADDR_BYTES * 8;
  localparam int unsigned LEN_W  = `UART_DBG_LEN_BYTES * 8;
  localparam int unsigned CNT_W  = $clog2(`UART_DBG_ADDR_BYTES);

  dbg_state_e       state_q;
  dbg_cmd_e         cmd_q;
  logic [CNT_W-1:0] cnt_q;
  logic             cyc_q;
  logic             send_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0] len_q;
  logic [7:0]       data_q;
  logic             wb_ack;
  logic             byte_done;

  assign wb_ack = cyc_q && wb_rsp_i.ack;

  // One data byte finished in either direction
  assign byte_done = (state_q == ST_RD_DATA && send_q && tx_ready_i) ||
                     (state_q == ST_WR_DATA && wb_ack);

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      cmd_q   <= CMD_ACK;
      cnt_q   <= '0;
      cyc_q   <= 1'b0;
      send_q  <= 1'b0;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (rx_byte_i.valid) begin
            cnt_q <= '0;
            case (rx_byte_i.data)
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q   <= dbg_cmd_e'(rx_byte_i.data);
                state_q <= ST_ADDR;
              end
              CMD_ACK: begin
                cmd_q   <= CMD_ACK;
                state_q <= ST_ACK;
              end
              // Unknown bytes are ignored
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_ADDR: begin
          if (rx_byte_i.valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(`UART_DBG_ADDR_BYTES - 1)) begin
              cnt_q   <= '0;
              state_q <= (cmd_q == CMD_EXEC) ? ST_EXEC : ST_LEN;
            end
          end
        end
        ST_LEN: begin
          if (rx_byte_i.valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(`UART_DBG_LEN_BYTES - 1)) begin
              cnt_q   <= '0;
              state_q <= ST_ACK;
            end
          end
        end
        // Launch pulse for one cycle before the ACK
        ST_EXEC: state_q <= ST_ACK;
        ST_ACK: begin
          if (tx_ready_i) begin
            case (cmd_q)
              CMD_READ:  state_q <= (len_q == '0) ? ST_EOT : ST_RD_DATA;
              CMD_WRITE: state_q <= (len_q == '0) ? ST_EOT : ST_WR_DATA;
              default:   state_q <= ST_IDLE;
            endcase
          end
        end
        ST_RD_DATA: begin
          // Fetch a byte, then send it
          if (!cyc_q && !send_q) begin
            cyc_q <= 1'b1;
          end
          if (wb_ack) begin
            cyc_q  <= 1'b0;
            send_q <= 1'b1;
          end
          if (send_q && tx_ready_i) begin
            send_q <= 1'b0;
            if (len_q == LEN_W'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_WR_DATA: begin
          if (rx_byte_i.valid && !cyc_q) begin
            cyc_q <= 1'b1;
          end
          if (wb_ack) begin
            cyc_q <= 1'b0;
            if (len_q == LEN_W'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_EOT: begin
          if (tx_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address and length come in LSB first, then count through the data
  always_ff @(posedge clk) begin
    if (rx_byte_i.valid && state_q == ST_ADDR) begin
      addr_q <= {rx_byte_i.data, addr_q[ADDR_W-1:8]};
    end
    if (rx_byte_i.valid && state_q == ST_LEN) begin
      len_q <= {rx_byte_i.data, len_q[LEN_W-1:8]};
    end
    if (rx_byte_i.valid && state_q == ST_WR_DATA && !cyc_q) begin
      data_q <= rx_byte_i.data;
    end
    if (wb_ack && state_q == ST_RD_DATA) begin
      data_q <= wb_rsp_i.dat;
    end
    if (byte_done) begin
      addr_q <= addr_q + 1'b1;
      len_q  <= len_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign tx_valid_o = (state_q == ST_ACK) || (state_q == ST_EOT) ||
                      (state_q == ST_RD_DATA && send_q);
  assign tx_data_o  = (state_q == ST_ACK) ? `UART_DBG_ACK :
                      (state_q == ST_EOT) ? `UART_DBG_EOT : data_q;

  assign wb_req_o = '{
    cyc: cyc_q,
    stb: cyc_q,
    we:  (cmd_q == CMD_WRITE),
    adr: addr_q,
    dat: data_q
  };

  assign exec_addr_o  = addr_q;
  assign exec_valid_o = (state_q == ST_EXEC);

  // Bus rules toward the RAM
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_req_o.stb && !wb_rsp_i.ack) |=> $stable(wb_req_o))
    else $error("uart_dbg_ctrl: request changed before ack");

endmodule

/* wb_byte_ram.sv */
/*
  Byte-wide single-port RAM on a Wishbone classic slave port.
  Indexed by the low address bits, so the space repeats every RAM size.
  Acks each strobe once, one cycle later, with the registered read data.
*/
`timescale 1ns/1ps
`include "uart_dbg_defs.svh"

module wb_byte_ram (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  uart_dbg_pkg::wb_req_t wb_req_i,
  output uart_dbg_pkg::wb_rsp_t wb_rsp_o
);

  localparam int unsigned IDX_W = $clog2(`UART_DBG_RAM_BYTES);

  logic [7:0]       mem_q [`UART_DBG_RAM_BYTES];
  logic [7:0]       rdat_q;
  logic             ack_q;
  logic [IDX_W-1:0] idx;
  logic             access;

  assign idx = wb_req_i.adr[IDX_W-1:0];

  // New access only while no ack is out
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_req_i.we) begin
        mem_q[idx] <= wb_req_i.dat;
      end
      rdat_q <= mem_q[idx];
    end
  end

  assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

/* uart_dbg_top.sv */
/*
  Top level of the UART debug server.
  Joins the serial receiver and transmitter, the protocol controller and
  the Wishbone byte RAM. The exec request leaves the design as a pulse.
*/
`timescale 1ns/1ps
`include "uart_dbg_defs.svh"

module uart_dbg_top (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              uart_rx_i,
  output logic                              uart_tx_o,
  output logic [`UART_DBG_ADDR_BYTES*8-1:0] exec_addr_o,
  output logic                              exec_valid_o
);

  import uart_dbg_pkg::*;

  byte_strm_t rx_byte;
  logic [7:0] tx_data;
  logic       tx_valid;
  logic       tx_ready;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;

  uart_rx i_uart_rx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .rx_i    ( uart_rx_i ),
    .byte_o  ( rx_byte   )
  );

  uart_tx i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_valid_i ( tx_valid  ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

  uart_dbg_ctrl i_uart_dbg_ctrl (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_byte_i    ( rx_byte      ),
    .tx_data_o    ( tx_data      ),
    .tx_valid_o   ( tx_valid     ),
    .tx_ready_i   ( tx_ready     ),
    .wb_req_o     ( wb_req       ),
    .wb_rsp_i     ( wb_rsp       ),
    .exec_addr_o  ( exec_addr_o  ),
    .exec_valid_o ( exec_valid_o )
  );

  wb_byte_ram i_wb_byte_ram (
    .clk      ( clk     ),
    .rst_n_i  ( rst_n_i ),
    .wb_req_i ( wb_req  ),
    .wb_rsp_o ( wb_rsp  )
  );

endmodule

/* tb_uart_dbg.sv */
/*
  Testbench for the UART debug server.
  A host model sends 8N1 command frames and a monitor collects the reply
  frames. Assertions check replies, RAM contents and the exec launch pulse.
*/
`timescale 1ns/1ps
`include "uart_dbg_defs.svh"

module tb_uart_dbg;

  localparam int CLKS         = `UART_DBG_CLKS_PER_BIT;
  localparam int FRAME_CYCLES = 10 * CLKS;
  // About 120 frames of traffic, three times over
  localparam int MAX_CYCLES   = 125 * FRAME_CYCLES * 3;
  localparam int DRV_DLY      = 2;
  localparam int NBYTES       = 16;

  logic        clk;
  logic        rst_n;
  logic        uart_rx;
  logic        uart_tx;
  logic [31:0] exec_addr;
  logic        exec_valid;

  logic [7:0]  rx_q[$];
  logic [7:0]  wr_data[NBYTES];
  logic [31:0] lfsr;
  logic [31:0] exec_exp;
  logic        exec_armed;
  logic        host_started;
  int          exec_count = 0;
  int          value_errors = 0;
  int          frame_errors = 0;
  int          rule_errors = 0;
  int          cycles = 0;
  string       test_name;

  uart_dbg_top dut_i (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n      ),
    .uart_rx_i    ( uart_rx    ),
    .uart_tx_o    ( uart_tx    ),
    .exec_addr_o  ( exec_addr  ),
    .exec_valid_o ( exec_valid )
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  task automatic check_byte(logic [7:0] exp, logic [7:0] act);
    assert (exp == act) else begin
      value_errors++;
      $display("** Error [%s] expected 0x%02h, actual 0x%02h", test_name, exp, act);
    end
  endtask

  task automatic check_count(int exp, int act);
    assert (exp == act) else begin
      value_errors++;
      $display("** Error [%s] expected %0d, actual %0d", test_name, exp, act);
    end
  endtask

  task automatic drive_bit(logic v);
    @(posedge clk);
    #DRV_DLY uart_rx = v;
    repeat (CLKS - 1) @(posedge clk);
  endtask

  task automatic send_byte(logic [7:0] b);
    host_started = 1'b1;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
  endtask

  // Field of n bytes, least significant first
  task automatic send_le(logic [31:0] v, int n);
    for (int i = 0; i < n; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic pop_byte(output logic [7:0] b);
    while (rx_q.size() == 0) begin
      @(posedge clk);
    end
    b = rx_q.pop_front();
  endtask

  // Any reply would be complete within two frames
  task automatic expect_silence();
    repeat (2 * FRAME_CYCLES) @(posedge clk);
    check_count(0, rx_q.size());
  endtask

  task automatic read_block(logic [31:0] addr);
    logic [7:0] b;
    send_byte(`UART_DBG_CMD_READ);
    send_le(addr, `UART_DBG_ADDR_BYTES);
    send_le(NBYTES, `UART_DBG_LEN_BYTES);
    pop_byte(b);
    check_byte(`UART_DBG_ACK, b);
    for (int i = 0; i < NBYTES; i++) begin
      pop_byte(b);
      check_byte(wr_data[i], b);
    end
    pop_byte(b);
    check_byte(`UART_DBG_EOT, b);
  endtask

  task automatic report_counts(int timeouts);
    $display("Errors: %0d value, %0d frame, %0d rule, %0d timeout",
             value_errors, frame_errors, rule_errors, timeouts);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors and rules
  //////////////////////////////////////////////////////////////////////

  // Reply frames, sampled mid-bit on the falling clock
  initial begin : reply_monitor
    logic [7:0] b;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (CLKS / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        frame_errors++;
        $display("Start bit on the DUT serial output did not stay low");
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS) @(negedge clk);
          b[i] = uart_tx;
        end
        repeat (CLKS) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          frame_errors++;
          $display("Stop bit missing on the DUT serial output");
        end
        rx_q.push_back(b);
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && exec_valid) begin
      exec_count++;
    end
  end

  // Quiet outputs until the first command frame
  assert property (@(posedge clk) disable iff (!rst_n)
    !host_started |-> (uart_tx && !exec_valid))
    else begin
      rule_errors++;
      $display("DUT output became active before any command was sent");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    exec_valid |-> (exec_armed && exec_addr == exec_exp))
    else begin
      rule_errors++;
      $display("** Error [%s] expected exec 0x%08h, actual 0x%08h",
               test_name, exec_exp, exec_addr);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    exec_valid |=> !exec_valid)
    else begin
      rule_errors++;
      $display("Exec pulse lasted more than one cycle");
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the DUT did not answer within %0d cycles", MAX_CYCLES);
      report_counts(1);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [7:0] b;
    int         base;
    rst_n        = 1'b0;
    uart_rx      = 1'b1;
    lfsr         = 32'h785c80dc;
    exec_exp     = '0;
    exec_armed   = 1'b0;
    host_started = 1'b0;
    test_name    = "reset";
    repeat (8) @(posedge clk);
    #DRV_DLY rst_n = 1'b1;
    // Idle stretch, watched by the quiet-output rule
    repeat (4 * CLKS) @(posedge clk);

    test_name = "ack_challenge";
    send_byte(`UART_DBG_ACK);
    pop_byte(b);
    check_byte(`UART_DBG_ACK, b);
    test_name = "ack_extra_bytes";
    expect_silence();

    test_name = "write";
    send_byte(`UART_DBG_CMD_WRITE);
    send_le(32'h100, `UART_DBG_ADDR_BYTES);
    send_le(NBYTES, `UART_DBG_LEN_BYTES);
    pop_byte(b);
    check_byte(`UART_DBG_ACK, b);
    for (int i = 0; i < NBYTES; i++) begin
      rand_byte(wr_data[i]);
      send_byte(wr_data[i]);
    end
    pop_byte(b);
    check_byte(`UART_DBG_EOT, b);

    test_name = "read_back";
    read_block(32'h100);
    // Same bytes one RAM size higher
    test_name = "read_alias";
    read_block(32'h100 + `UART_DBG_RAM_BYTES);

    test_name  = "exec";
    base       = exec_count;
    exec_exp   = 32'h8000_1234;
    exec_armed = 1'b1;
    send_byte(`UART_DBG_CMD_EXEC);
    send_le(32'h8000_1234, `UART_DBG_ADDR_BYTES);
    pop_byte(b);
    check_byte(`UART_DBG_ACK, b);
    exec_armed = 1'b0;
    check_count(base + 1, exec_count);

    test_name = "unknown_byte";
    base      = exec_count;
    send_byte(8'h55);
    expect_silence();
    check_count(base, exec_count);

    report_counts(0);
    if (value_errors + frame_errors + rule_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
uart_dbg_pkg.sv
uart_rx.sv
uart_tx.sv
uart_dbg_ctrl.sv
wb_byte_ram.sv
uart_dbg_top.sv
tb_uart_dbg.sv

/* Makefile */
# Verilator flow for the UART debug server
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_uart_dbg
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST)) uart_dbg_defs.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) \
	  --top-module $(TOP) $(VFLAGS)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
	  --top-module $(TOP) -Mdir $(OBJ_DIR) $(VFLAGS)

sim: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
